/* build.f */
cc_pkg.sv
queue_meta.sv
cc_rate_ctrl.sv
cc_pacer.sv
cc_queue.sv
tb_cc_queue.sv

/* Bender.yml */
package:
  name: cc_queue

dependencies: {}

sources:
  # design, package first
  - cc_pkg.sv
  - queue_meta.sv
  - cc_rate_ctrl.sv
  - cc_pacer.sv
  - cc_queue.sv

  # testbench
  - target: test
    files:
      - tb_cc_queue.sv

/* tb_cc_queue.sv */
module tb_cc_queue;

    timeunit 1ns;
    timeprecision 1ps;

    import cc_pkg::*;

    // phase lengths in clock cycles
    localparam int RESET_CYC = 5;
    localparam int CYC_PACE  = 4000;
    localparam int CYC_MARK  = 3000;
    localparam int CYC_IDLE  = 4000;
    localparam int STIM_CYC  = RESET_CYC + CYC_PACE + CYC_MARK + CYC_IDLE;
    localparam int CYCLE_LIMIT = STIM_CYC + QDEPTH * (int'(RC_INIT) + 2);

    logic  aclk;
    logic  aresetn;
    logic  ecn_mark;
    logic  ecn_write_rdy;
    logic  s_req_valid;
    logic  s_req_ready;
    dreq_t s_req_data;
    logic  m_req_valid;
    logic  m_req_ready;
    dreq_t m_req_data;
    rate_t rate_cur;

    integer seed;
    dreq_t  sb [$];
    int     n_cycle;
    int     last_out;
    logic   have_last;
    int     wd_cycles = 0;

    // reference model of the reaction point
    tstamp_t m_timer;
    tstamp_t m_lmark;
    tstamp_t m_lcut;
    rate_t   m_tgt;
    rate_t   m_cur;
    sa_idx_t m_idx;
    int      m_acks;
    int      m_ticks;
    int      m_tst;
    int      m_ast;
    logic    m_inc;
    logic    seen_fast;
    logic    seen_add;
    logic    seen_hyper;

    cc_queue UUT (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .ecn_mark      (ecn_mark),
        .ecn_write_rdy (ecn_write_rdy),
        .s_req_valid   (s_req_valid),
        .s_req_ready   (s_req_ready),
        .s_req_data    (s_req_data),
        .m_req_valid   (m_req_valid),
        .m_req_ready   (m_req_ready),
        .m_req_data    (m_req_data),
        .rate_cur      (rate_cur)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        wd_cycles = wd_cycles + 1;
        if (wd_cycles > CYCLE_LIMIT) begin
            $display("timeout: queue did not drain");
            stop_on_error();
        end
    end

    // ================================================
    // checks
    // ================================================
    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_req(input dreq_t got, input dreq_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: m_req_data %h, expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_rate(input rate_t got, input rate_t exp);
        if (got !== exp || got < RATE_FLOOR) begin
            $display("Error at time %0t: rate_cur %0d, expected %0d", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_gap(input int gap, input rate_t rate);
        if (gap < int'(rate) + 1) begin
            $display("Error at time %0t: departures %0d cycles apart at rate_cur %0d",
                     $time, gap, rate);
            stop_on_error();
        end
    endtask

    function automatic logic chance(input int pct);
        int r;
        r = $random(seed);
        return ($unsigned(r) % 100) < pct;
    endfunction

    // ================================================
    // rate model stepped once per rising edge
    // ================================================
    task automatic model_reset();
        m_timer = '0;
        m_lmark = '0;
        m_lcut  = '0;
        m_tgt   = RT_INIT;
        m_cur   = RC_INIT;
        m_idx   = '0;
        m_acks  = 0;
        m_ticks = 0;
        m_tst   = 0;
        m_ast   = 0;
        m_inc   = 1'b0;
    endtask

    task automatic model_step(input logic ack, input logic mark);
        inc_mode_t mode;
        rate_t     mean;
        rate_t     tgt_n;
        rate_t     cur_n;
        sa_idx_t   idx_n;
        tstamp_t   lmark_n;
        tstamp_t   lcut_n;
        int        acks_n;
        int        ticks_n;
        int        tst_n;
        int        ast_n;
        logic      inc_n;

        // step type comes from the event of the last cycle
        if (!m_inc) begin
            mode = INC_NONE;
        end else if (m_tst == STAGE_F && m_ast == STAGE_F) begin
            mode = INC_HYPER;
            seen_hyper = 1'b1;
        end else if (m_tst == STAGE_F || m_ast == STAGE_F) begin
            mode = INC_ADDITIVE;
            seen_add = 1'b1;
        end else begin
            mode = INC_FAST;
            seen_fast = 1'b1;
        end
        mean    = rate_t'((int'(m_tgt) + int'(m_cur)) / 2);
        tgt_n   = m_tgt;
        cur_n   = m_cur;
        idx_n   = m_idx;
        lmark_n = m_lmark;
        lcut_n  = m_lcut;
        acks_n  = m_acks;
        ticks_n = m_ticks + 1;
        tst_n   = m_tst;
        ast_n   = m_ast;
        inc_n   = 1'b0;

        if (ack) begin
            acks_n = m_acks + 1;
            if (mark) begin
                if (m_timer - m_lcut > MIN_MARK_GAP) begin
                    tgt_n = m_cur;
                    if (m_cur <= CUT_LIMIT) begin
                        cur_n = rate_t'((int'(m_cur) * int'(SA_TABLE[m_idx])) / 128);
                    end
                    if (m_idx > 0) begin
                        idx_n = m_idx - 1;
                    end
                    lcut_n  = m_timer;
                    acks_n  = 0;
                    ticks_n = 0;
                    tst_n   = 0;
                    ast_n   = 0;
                end
                lmark_n = m_timer;
            end
        end
        if (m_timer - m_lmark > ALPHA_TIMEOUT) begin
            if (m_idx < SA_MAX) begin
                idx_n = m_idx + 1;
            end
            lmark_n = m_timer;
        end
        if (m_ticks > TIME_LIMIT) begin
            ticks_n = 0;
            inc_n   = 1'b1;
            tst_n   = (m_tst < STAGE_F) ? m_tst + 1 : m_tst;
        end
        if (m_acks > ACK_LIMIT) begin
            acks_n = 0;
            inc_n  = 1'b1;
            ast_n  = (m_ast < STAGE_F) ? m_ast + 1 : m_ast;
        end
        if (mode == INC_ADDITIVE) begin
            tgt_n = (int'(m_tgt) + 3 < int'(R_AI)) ? rate_t'(1) : m_tgt - R_AI;
        end
        if (mode != INC_NONE) begin
            cur_n = mean;
        end
        cur_n = (cur_n < RATE_FLOOR) ? RATE_FLOOR : cur_n;
        tgt_n = (tgt_n < RATE_FLOOR) ? RATE_FLOOR : tgt_n;

        m_timer = m_timer + 1;
        m_tgt   = tgt_n;
        m_cur   = cur_n;
        m_idx   = idx_n;
        m_lmark = lmark_n;
        m_lcut  = lcut_n;
        m_acks  = acks_n;
        m_ticks = ticks_n;
        m_tst   = tst_n;
        m_ast   = ast_n;
        m_inc   = inc_n;
    endtask

    // ================================================
    // one clock cycle of stimulus from 2 ns after an edge
    // ================================================
    task automatic run_cycle(input int p_req, input int p_ack, input int p_mark,
                             input logic pace_chk);
        logic  in_fire;
        logic  out_fire;
        dreq_t in_data;
        dreq_t out_data;
        logic  ack;
        logic  mark;

        // a pending request keeps valid and data until taken
        if (!s_req_valid) begin
            if (chance(p_req)) begin
                s_req_valid = 1'b1;
                s_req_data  = dreq_t'({$random(seed), $random(seed)});
            end
        end
        m_req_ready = chance(70);
        ack  = chance(p_ack);
        mark = 1'b0;
        if (ack) begin
            mark = chance(p_mark);
        end
        ecn_write_rdy = ack;
        ecn_mark      = mark;

        in_fire  = s_req_valid && s_req_ready;
        out_fire = m_req_valid && m_req_ready;
        in_data  = s_req_data;
        out_data = m_req_data;
        if (out_fire && pace_chk && have_last) begin
            check_gap(n_cycle + 1 - last_out, rate_cur);
        end

        @(posedge aclk);
        n_cycle = n_cycle + 1;
        model_step(ack, mark);
        if (out_fire) begin
            if (sb.size() == 0) begin
                $display("output request appeared without a matching input request");
                stop_on_error();
            end else begin
                check_req(out_data, sb.pop_front());
            end
            last_out  = n_cycle;
            have_last = 1'b1;
        end
        if (in_fire) begin
            sb.push_back(in_data);
        end

        #2;
        if (in_fire) begin
            s_req_valid = 1'b0;
        end
        check_rate(rate_cur, m_cur);
    endtask

    initial begin
        seed          = 67;
        aresetn       = 1'b0;
        ecn_mark      = 1'b0;
        ecn_write_rdy = 1'b0;
        s_req_valid   = 1'b0;
        s_req_data    = '0;
        m_req_ready   = 1'b0;
        n_cycle       = 0;
        last_out      = 0;
        have_last     = 1'b0;
        seen_fast     = 1'b0;
        seen_add      = 1'b0;
        seen_hyper    = 1'b0;

        repeat (RESET_CYC) @(posedge aclk);
        #2;
        aresetn = 1'b1;
        model_reset();
        check_rate(rate_cur, RC_INIT);
        check_flag("m_req_valid", m_req_valid, 1'b0);
        check_flag("s_req_ready", s_req_ready, 1'b1);

        // traffic with no acks and pacing checked
        repeat (CYC_PACE) run_cycle(30, 0, 0, 1'b1);
        // marked acks with some too close for a cut
        have_last = 1'b0;
        repeat (CYC_MARK) run_cycle(30, 20, 50, 1'b0);
        // unmarked acks and no new traffic
        repeat (CYC_IDLE) run_cycle(0, 30, 0, 1'b0);
        while (sb.size() != 0 || s_req_valid) begin
            run_cycle(0, 0, 0, 1'b0);
        end
        check_flag("m_req_valid", m_req_valid, 1'b0);

        if (seen_fast && seen_add && seen_hyper) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("stimulus did not reach every increase step type");
            stop_on_error();
        end
    end

endmodule

/* cc_queue.sv */
module cc_queue (
    input  logic          aclk,
    input  logic          aresetn,

    input  logic          ecn_mark,
    input  logic          ecn_write_rdy,

    input  logic          s_req_valid,
    output logic          s_req_ready,
    input  cc_pkg::dreq_t s_req_data,

    output logic          m_req_valid,
    input  logic          m_req_ready,
    output cc_pkg::dreq_t m_req_data,

    output cc_pkg::rate_t rate_cur
);

    import cc_pkg::*;

    // FIFO head toward the pacer
    logic  q_valid;
    logic  q_ready;
    dreq_t q_data;

    queue_meta inst_cq (
        .aclk    (aclk),
        .aresetn (aresetn),
        .s_valid (s_req_valid),
        .s_ready (s_req_ready),
        .s_data  (s_req_data),
        .m_valid (q_valid),
        .m_ready (q_ready),
        .m_data  (q_data)
    );

    cc_rate_ctrl inst_rc (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .ecn_write_rdy (ecn_write_rdy),
        .ecn_mark      (ecn_mark),
        .rate_cur      (rate_cur)
    );

    cc_pacer inst_pacer (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .rate_cur    (rate_cur),
        .q_valid     (q_valid),
        .q_ready     (q_ready),
        .q_data      (q_data),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req_data  (m_req_data)
    );

endmodule

/* cc_pacer.sv */
module cc_pacer (
    input  logic          aclk,
    input  logic          aresetn,

    input  cc_pkg::rate_t rate_cur,

    input  logic          q_valid,
    output logic          q_ready,
    input  cc_pkg::dreq_t q_data,

    output logic          m_req_valid,
    input  logic          m_req_ready,
    output cc_pkg::dreq_t m_req_data
);

    import cc_pkg::*;

    tstamp_t gap_cnt;
    logic    gap_open;
    logic    m_fire;

    assign gap_open = gap_cnt > rate_cur;
    assign m_fire   = m_req_valid && m_req_ready;

    // take the head only into an empty output stage
    assign q_ready = gap_open && !m_req_valid;

    // ================================================
    // gap timer and output stage
    // ================================================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gap_cnt     <= '0;
            m_req_valid <= 1'b0;
        end else begin
            if (m_fire) begin
                gap_cnt     <= '0;
                m_req_valid <= 1'b0;
            end else begin
                if (gap_cnt != '1) begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
                if (q_valid && q_ready) begin
                    m_req_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (q_valid && q_ready) begin
            m_req_data <= q_data;
        end
    end

    a_hold_data: assert property (@(posedge aclk) disable iff (!aresetn)
        (m_req_valid && !m_req_ready) |=> (m_req_valid && $stable(m_req_data)))
        else $error("cc_pacer: output changed under back-pressure");

endmodule

/* cc_rate_ctrl.sv */
module cc_rate_ctrl (
    input  logic          aclk,
    input  logic          aresetn,

    input  logic          ecn_write_rdy,
    input  logic          ecn_mark,

    output cc_pkg::rate_t rate_cur
);

    import cc_pkg::*;

    // registered state
    tstamp_t    timer;
    rate_t      rate_tgt;
    sa_idx_t    sa_idx;
    tstamp_t    t_last_mark;
    tstamp_t    t_last_cut;
    logic [7:0] ack_cnt;
    logic [7:0] time_cnt;
    logic [2:0] tc_stage;
    logic [2:0] ac_stage;
    logic       inc_event;

    // next state
    tstamp_t    timer_n;
    rate_t      rate_tgt_n;
    rate_t      rate_cur_n;
    sa_idx_t    sa_idx_n;
    tstamp_t    t_last_mark_n;
    tstamp_t    t_last_cut_n;
    logic [7:0] ack_cnt_n;
    logic [7:0] time_cnt_n;
    logic [2:0] tc_stage_n;
    logic [2:0] ac_stage_n;
    logic       inc_event_n;

    // helpers
    inc_mode_t   inc_mode;
    logic        cut_ok;
    logic        alpha_up;
    logic [16:0] rate_sum;
    rate_t       rate_mean;
    logic [24:0] cut_prod;
    rate_t       rate_cut;

    assign cut_ok   = ecn_write_rdy && ecn_mark && ((timer - t_last_cut) > MIN_MARK_GAP);
    assign alpha_up = (timer - t_last_mark) > ALPHA_TIMEOUT;

    assign rate_sum  = {1'b0, rate_tgt} + {1'b0, rate_cur};
    assign rate_mean = rate_sum[16:1];
    assign cut_prod  = rate_cur * SA_TABLE[sa_idx];
    assign rate_cut  = cut_prod[22:7];

    // ================================================
    // increase decision from the stage counters
    // ================================================
    always_comb begin
        if (!inc_event) begin
            inc_mode = INC_NONE;
        end else if (tc_stage >= STAGE_F && ac_stage >= STAGE_F) begin
            inc_mode = INC_HYPER;
        end else if (tc_stage >= STAGE_F || ac_stage >= STAGE_F) begin
            inc_mode = INC_ADDITIVE;
        end else begin
            inc_mode = INC_FAST;
        end
    end

    // ================================================
    // reaction point update where later steps take priority
    // ================================================
    always_comb begin
        timer_n       = timer + 1'b1;
        rate_tgt_n    = rate_tgt;
        rate_cur_n    = rate_cur;
        sa_idx_n      = sa_idx;
        t_last_mark_n = t_last_mark;
        t_last_cut_n  = t_last_cut;
        ack_cnt_n     = ack_cnt;
        time_cnt_n    = time_cnt + 1'b1;
        tc_stage_n    = tc_stage;
        ac_stage_n    = ac_stage;
        inc_event_n   = 1'b0;

        if (ecn_write_rdy) begin
            ack_cnt_n = ack_cnt + 1'b1;
            if (ecn_mark) begin
                // marks too close to the last cut only refresh the timestamp
                if (cut_ok) begin
                    rate_tgt_n = rate_cur;
                    if (rate_cur <= CUT_LIMIT) begin
                        rate_cur_n = rate_cut;
                    end
                    if (sa_idx != '0) begin
                        sa_idx_n = sa_idx - 1'b1;
                    end
                    t_last_cut_n = timer;
                    time_cnt_n   = '0;
                    ack_cnt_n    = '0;
                    tc_stage_n   = '0;
                    ac_stage_n   = '0;
                end
                t_last_mark_n = timer;
            end
        end

        // a quiet period moves toward gentler cuts
        if (alpha_up) begin
            if (sa_idx != SA_MAX) begin
                sa_idx_n = sa_idx + 1'b1;
            end
            t_last_mark_n = timer;
        end

        if (time_cnt > TIME_LIMIT) begin
            time_cnt_n  = '0;
            inc_event_n = 1'b1;
            if (tc_stage < STAGE_F) begin
                tc_stage_n = tc_stage + 1'b1;
            end
        end

        if (ack_cnt > ACK_LIMIT) begin
            ack_cnt_n   = '0;
            inc_event_n = 1'b1;
            if (ac_stage < STAGE_F) begin
                ac_stage_n = ac_stage + 1'b1;
            end
        end

        case (inc_mode)
            INC_FAST, INC_HYPER: begin
                rate_cur_n = rate_mean;
            end
            INC_ADDITIVE: begin
                if (({1'b0, rate_tgt} + 17'd3) < {1'b0, R_AI}) begin
                    rate_tgt_n = 16'd1;
                end else begin
                    rate_tgt_n = rate_tgt - R_AI;
                end
                rate_cur_n = rate_mean;
            end
            default: begin
            end
        endcase

        // floor on both rates
        if (rate_cur_n < RATE_FLOOR) begin
            rate_cur_n = RATE_FLOOR;
        end
        if (rate_tgt_n < RATE_FLOOR) begin
            rate_tgt_n = RATE_FLOOR;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            timer       <= '0;
            rate_tgt    <= RT_INIT;
            rate_cur    <= RC_INIT;
            sa_idx      <= '0;
            t_last_mark <= '0;
            t_last_cut  <= '0;
            ack_cnt     <= '0;
            time_cnt    <= '0;
            tc_stage    <= '0;
            ac_stage    <= '0;
            inc_event   <= 1'b0;
        end else begin
            timer       <= timer_n;
            rate_tgt    <= rate_tgt_n;
            rate_cur    <= rate_cur_n;
            sa_idx      <= sa_idx_n;
            t_last_mark <= t_last_mark_n;
            t_last_cut  <= t_last_cut_n;
            ack_cnt     <= ack_cnt_n;
            time_cnt    <= time_cnt_n;
            tc_stage    <= tc_stage_n;
            ac_stage    <= ac_stage_n;
            inc_event   <= inc_event_n;
        end
    end

    a_rate_floor: assert property (@(posedge aclk) disable iff (!aresetn)
        (rate_cur >= RATE_FLOOR) && (rate_tgt >= RATE_FLOOR))
        else $error("cc_rate_ctrl: rate below floor");

    a_idx_max: assert property (@(posedge aclk) disable iff (!aresetn)
        sa_idx <= SA_MAX)
        else $error("cc_rate_ctrl: alpha index out of table");

endmodule

/* queue_meta.sv */
module queue_meta (
    input  logic          aclk,
    input  logic          aresetn,

    input  logic          s_valid,
    output logic          s_ready,
    input  cc_pkg::dreq_t s_data,

    output logic          m_valid,
    input  logic          m_ready,
    output cc_pkg::dreq_t m_data
);

    import cc_pkg::*;

    dreq_t              mem [0:QDEPTH-1];
    logic [QPTR_W-1:0]  wr_ptr;
    logic [QPTR_W-1:0]  rd_ptr;
    logic [QCNT_W-1:0]  count;
    logic               push;
    logic               pop;

    assign s_ready = (count != QCNT_W'(QDEPTH));
    assign m_valid = (count != '0);
    assign m_data  = mem[rd_ptr];

    assign push = s_valid && s_ready;
    assign pop  = m_valid && m_ready;

    // payload storage
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    // ================================================
    // pointers and occupancy
    // ================================================
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // a full FIFO has its write pointer wrapped onto the read pointer
    a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
        (count == QCNT_W'(QDEPTH)) |-> (wr_ptr == rd_ptr))
        else $error("queue_meta: pointers apart while full");

    // an empty FIFO has both pointers on the same slot
    a_no_pop_empty: assert property (@(posedge aclk) disable iff (!aresetn)
        (count == '0) |-> (wr_ptr == rd_ptr))
        else $error("queue_meta: pointers apart while empty");

endmodule

/* cc_pkg.sv */
package cc_pkg;

    // ================================================
    // widths with a meaning
    // ================================================

    // rate as minimum cycles between two departures
    typedef logic [15:0] rate_t;

    // free-running cycle time and event timestamps
    typedef logic [31:0] tstamp_t;

    // index into the alpha factor table
    typedef logic [4:0] sa_idx_t;

    // work request as it travels through the queue
    typedef struct packed {
        logic [47:0] vaddr;
        logic [13:0] len;
        logic        opcode;
        logic        last;
    } dreq_t;

    // increase decision of the reaction point
    typedef enum logic [1:0] {
        INC_NONE,
        INC_FAST,
        INC_ADDITIVE,
        INC_HYPER
    } inc_mode_t;

    // ================================================
    // queue sizing
    // ================================================
    localparam int QDEPTH = 20;
    localparam int QPTR_W = $clog2(QDEPTH);
    localparam int QCNT_W = $clog2(QDEPTH + 1);

    // ================================================
    // DCQCN constants
    // ================================================
    localparam rate_t   RT_INIT       = 16'd128;
    localparam rate_t   RC_INIT       = 16'd8192;
    localparam tstamp_t MIN_MARK_GAP  = 32'd200;
    localparam tstamp_t ALPHA_TIMEOUT = 32'd600;
    localparam rate_t   R_AI          = 16'd60;
    localparam rate_t   RATE_FLOOR    = 16'd50;
    localparam rate_t   CUT_LIMIT     = 16'd2048;
    localparam logic [2:0] STAGE_F    = 3'd5;
    localparam logic [7:0] TIME_LIMIT = 8'd150;
    localparam logic [7:0] ACK_LIMIT  = 8'd10;
    localparam sa_idx_t SA_MAX        = 5'd28;

    // cut factors in units of 1/128
    // index 0 doubles the gap
    localparam logic [8:0] SA_TABLE [0:28] = '{
        9'd256, 9'd241, 9'd228, 9'd218, 9'd209, 9'd201, 9'd194, 9'd188,
        9'd182, 9'd178, 9'd173, 9'd170, 9'd166, 9'd163, 9'd161, 9'd158,
        9'd156, 9'd154, 9'd152, 9'd150, 9'd148, 9'd147, 9'd146, 9'd144,
        9'd143, 9'd142, 9'd141, 9'd140, 9'd139
    };

endpackage
